/* rtl/imager_defs.svh */
`ifndef IMAGER_DEFS_SVH
`define IMAGER_DEFS_SVH

// stream and bus widths.
`define PIXEL_WIDTH    10
`define DI_DATA_WIDTH  32
`define DI_ADDR_WIDTH  32
`define DIM_WIDTH      12

// entries held by each capture buffer.
`define CAPTURE_DEPTH  16

// idle cycles after each line, then extra idle cycles before the next frame.
`define LINE_BLANK     4
`define FRAME_BLANK    8

`endif

/* rtl/di_pkg.sv */
`include "imager_defs.svh"

package di_pkg;

   // terminal addresses on the DI bus.
   typedef enum logic [15:0] {
      TERM_CONFIG      = 16'd1,
      TERM_CAPTURE_IN  = 16'd2,
      TERM_CAPTURE_OUT = 16'd3
   } term_t;

   typedef enum logic [`DI_ADDR_WIDTH-1:0] {
      CFG_ENABLE     = 0,
      CFG_STREAM_SEL = 1,
      CFG_ROWS       = 2,
      CFG_COLS       = 3,
      CFG_SEED       = 4
   } cfg_reg_t;

   // CAP_INFO layout: dtype in 1:0, overflow in 8, level in 20:16.
   typedef enum logic [`DI_ADDR_WIDTH-1:0] {
      CAP_DATA = 0,
      CAP_INFO = 1
   } cap_reg_t;

   typedef struct packed {
      logic [`DI_DATA_WIDTH-1:0] datao;
      logic                      read_rdy;
      logic                      write_rdy;
      logic [15:0]               status;
   } di_resp_t;

endpackage

/* rtl/stream_pkg.sv */
`include "imager_defs.svh"

package stream_pkg;

   typedef logic [`PIXEL_WIDTH-1:0] pixel_t;

   typedef enum logic [1:0] {
      DTYPE_PIXEL,
      DTYPE_LINE_START,
      DTYPE_FRAME_START
   } dtype_t;

   typedef enum logic {
      SEL_RAW,
      SEL_PACKED
   } stream_sel_t;

   typedef struct packed {
      dtype_t dtype;
      pixel_t data;
   } raw_item_t;

   // formatted word, either one pixel or a packed pair.
   typedef struct packed {
      dtype_t      dtype;
      logic [31:0] data;
   } fmt_item_t;

endpackage

/* rtl/di_bus_if.sv */
`timescale 1ns/1ns
`include "imager_defs.svh"

// decoded DI request, one instance per terminal.
interface di_bus_if;
   logic [`DI_ADDR_WIDTH-1:0] reg_addr;
   logic [`DI_DATA_WIDTH-1:0] reg_datai;
   logic                      read;
   logic                      write;
   logic                      sel;

   modport decoder (
      output reg_addr,
      output reg_datai,
      output read,
      output write,
      output sel
   );

   modport terminal (
      input reg_addr,
      input reg_datai,
      input read,
      input write,
      input sel
   );
endinterface

/* rtl/di_term_decoder.sv */
`timescale 1ns/1ns
`include "imager_defs.svh"

module di_term_decoder (
   input  di_pkg::term_t             term_addr,
   input  logic [`DI_ADDR_WIDTH-1:0] reg_addr,
   input  logic [`DI_DATA_WIDTH-1:0] reg_datai,
   input  logic                      read,
   input  logic                      write,
   input  di_pkg::di_resp_t          cfg_resp,
   input  di_pkg::di_resp_t          in_resp,
   input  di_pkg::di_resp_t          out_resp,
   output logic [`DI_DATA_WIDTH-1:0] reg_datao,
   output logic                      read_rdy,
   output logic                      write_rdy,
   output logic [15:0]               transfer_status,
   di_bus_if.decoder                 cfg_bus,
   di_bus_if.decoder                 in_bus,
   di_bus_if.decoder                 out_bus
);
   import di_pkg::*;

   logic     cfg_sel;
   logic     in_sel;
   logic     out_sel;
   di_resp_t resp;

   assign cfg_sel = (term_addr == TERM_CONFIG);
   assign in_sel  = (term_addr == TERM_CAPTURE_IN);
   assign out_sel = (term_addr == TERM_CAPTURE_OUT);

   // every terminal sees the request, only one sees its select.
   assign cfg_bus.reg_addr  = reg_addr;
   assign cfg_bus.reg_datai = reg_datai;
   assign cfg_bus.read      = read;
   assign cfg_bus.write     = write;
   assign cfg_bus.sel       = cfg_sel;

   assign in_bus.reg_addr   = reg_addr;
   assign in_bus.reg_datai  = reg_datai;
   assign in_bus.read       = read;
   assign in_bus.write      = write;
   assign in_bus.sel        = in_sel;

   assign out_bus.reg_addr  = reg_addr;
   assign out_bus.reg_datai = reg_datai;
   assign out_bus.read      = read;
   assign out_bus.write     = write;
   assign out_bus.sel       = out_sel;

   // priority mux, unknown terminals get the default answer.
   always_comb begin
      if (cfg_sel) begin
         resp = cfg_resp;
      end else if (in_sel) begin
         resp = in_resp;
      end else if (out_sel) begin
         resp = out_resp;
      end else begin
         resp.datao     = '0;
         resp.read_rdy  = 1'b1;
         resp.write_rdy = 1'b1;
         resp.status    = 16'd1;
      end
   end

   assign reg_datao       = resp.datao;
   assign read_rdy        = resp.read_rdy;
   assign write_rdy       = resp.write_rdy;
   assign transfer_status = resp.status;

endmodule

/* rtl/config_terminal.sv */
`timescale 1ns/1ns
`include "imager_defs.svh"

module config_terminal (
   input  logic                   clk,
   input  logic                   resetb,
   di_bus_if.terminal             bus,
   output di_pkg::di_resp_t       resp,
   output logic                   enable,
   output stream_pkg::stream_sel_t stream_sel,
   output logic [`DIM_WIDTH-1:0]  rows,
   output logic [`DIM_WIDTH-1:0]  cols,
   output stream_pkg::pixel_t     seed
);
   import di_pkg::*;
   import stream_pkg::*;

   always_ff @(posedge clk) begin
      if (!resetb) begin
         enable     <= 1'b0;
         stream_sel <= SEL_RAW;
         rows       <= '0;
         cols       <= '0;
         seed       <= '0;
      end else if (bus.sel && bus.write) begin
         case (bus.reg_addr)
            CFG_ENABLE:     enable     <= bus.reg_datai[0];
            CFG_STREAM_SEL: stream_sel <= stream_sel_t'(bus.reg_datai[0]);
            CFG_ROWS:       rows       <= bus.reg_datai[`DIM_WIDTH-1:0];
            CFG_COLS:       cols       <= bus.reg_datai[`DIM_WIDTH-1:0];
            CFG_SEED:       seed       <= bus.reg_datai[`PIXEL_WIDTH-1:0];
            default: ;
         endcase
      end
   end

   // readback.
   always_comb begin
      resp           = '0;
      resp.read_rdy  = 1'b1;
      resp.write_rdy = 1'b1;
      case (bus.reg_addr)
         CFG_ENABLE:     resp.datao[0] = enable;
         CFG_STREAM_SEL: resp.datao[0] = stream_sel;
         CFG_ROWS:       resp.datao[`DIM_WIDTH-1:0] = rows;
         CFG_COLS:       resp.datao[`DIM_WIDTH-1:0] = cols;
         CFG_SEED:       resp.datao[`PIXEL_WIDTH-1:0] = seed;
         default: ;
      endcase
   end

   // the imager reads the frame size live, so the host must stop it first.
   assert property (@(posedge clk) disable iff (!resetb)
      (bus.sel && bus.write && bus.reg_addr inside {CFG_ROWS, CFG_COLS, CFG_SEED})
      |-> !enable);

endmodule

/* rtl/pattern_imager.sv */
`timescale 1ns/1ns
`include "imager_defs.svh"

module pattern_imager (
   input  logic                  clk,
   input  logic                  resetb,
   input  logic                  enable,
   input  logic [`DIM_WIDTH-1:0] rows,
   input  logic [`DIM_WIDTH-1:0] cols,
   input  stream_pkg::pixel_t    seed,
   output logic                  valid,
   output stream_pkg::dtype_t    dtype,
   output stream_pkg::pixel_t    pixel
);
   import stream_pkg::*;

   localparam int BLANK_W = $clog2(`LINE_BLANK + `FRAME_BLANK);
   localparam logic [BLANK_W-1:0] LINE_LAST  = BLANK_W'(`LINE_BLANK - 1);
   localparam logic [BLANK_W-1:0] FRAME_LAST = BLANK_W'(`FRAME_BLANK - 1);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ACTIVE,
      ST_LINE_BLANK,
      ST_FRAME_BLANK
   } state_t;

   state_t              state;
   logic [`DIM_WIDTH-1:0] row;
   logic [`DIM_WIDTH-1:0] col;
   logic [BLANK_W-1:0]  blank;
   pixel_t              acc;

   always_ff @(posedge clk) begin
      if (!resetb) begin
         state <= ST_IDLE;
         row   <= '0;
         col   <= '0;
         blank <= '0;
      end else if (!enable) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE, ST_FRAME_BLANK: begin
               blank <= blank + 1'b1;
               if ((state == ST_IDLE || blank == FRAME_LAST) && rows != '0 && cols != '0) begin
                  state <= ST_ACTIVE;
                  row   <= '0;
                  col   <= '0;
                  acc   <= seed;
               end
            end
            ST_ACTIVE: begin
               acc <= acc + 1'b1;
               col <= col + 1'b1;
               if (col == cols - 1'b1) begin
                  col   <= '0;
                  blank <= '0;
                  state <= ST_LINE_BLANK;
               end
            end
            default: begin
               blank <= blank + 1'b1;
               if (blank == LINE_LAST) begin
                  blank <= '0;
                  if (row == rows - 1'b1) begin
                     state <= ST_FRAME_BLANK;
                  end else begin
                     row   <= row + 1'b1;
                     state <= ST_ACTIVE;
                  end
               end
            end
         endcase
      end
   end

   assign valid = (state == ST_ACTIVE);
   assign pixel = acc;
   assign dtype = (col != '0) ? DTYPE_PIXEL :
                  (row == '0) ? DTYPE_FRAME_START : DTYPE_LINE_START;

   // every line is followed by its full blank.
   assert property (@(posedge clk) disable iff (!resetb || !enable)
      $fell(valid) |-> !valid [*`LINE_BLANK]);

endmodule

/* rtl/pixel_formatter.sv */
`timescale 1ns/1ns
`include "imager_defs.svh"

module pixel_formatter (
   input  logic                    clk,
   input  logic                    resetb,
   input  stream_pkg::stream_sel_t stream_sel,
   input  logic                    valid,
   input  stream_pkg::dtype_t      dtype,
   input  stream_pkg::pixel_t      pixel,
   output logic                    fmt_valid,
   output stream_pkg::fmt_item_t   fmt_item
);
   import stream_pkg::*;

   localparam int HALF_PAD = 16 - $bits(pixel_t);
   localparam int WORD_PAD = 32 - $bits(pixel_t);

   logic   half;
   logic   raw_issue;
   logic   pair_issue;
   pixel_t first_pixel;
   dtype_t first_dtype;

   assign raw_issue  = valid && (stream_sel == SEL_RAW);
   // a line start always opens a new pair.
   assign pair_issue = valid && (stream_sel == SEL_PACKED) && half && (dtype == DTYPE_PIXEL);

   always_ff @(posedge clk) begin
      if (!resetb) begin
         fmt_valid <= 1'b0;
         half      <= 1'b0;
      end else begin
         fmt_valid <= raw_issue || pair_issue;
         if (raw_issue || pair_issue) begin
            half <= 1'b0;
         end else if (valid) begin
            half <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (raw_issue) begin
         fmt_item.dtype <= dtype;
         fmt_item.data  <= {{WORD_PAD{1'b0}}, pixel};
      end else if (pair_issue) begin
         fmt_item.dtype <= first_dtype;
         fmt_item.data  <= {{HALF_PAD{1'b0}}, pixel, {HALF_PAD{1'b0}}, first_pixel};
      end else if (valid) begin
         first_pixel <= pixel;
         first_dtype <= dtype;
      end
   end

   // odd column counts would leave a pair open at the next line.
   assert property (@(posedge clk) disable iff (!resetb)
      (valid && stream_sel == SEL_PACKED && dtype == DTYPE_LINE_START) |-> !half);

endmodule

/* rtl/capture_fifo.sv */
`timescale 1ns/1ns
`include "imager_defs.svh"

module capture_fifo #(
   parameter type payload_t = stream_pkg::raw_item_t
) (
   input  logic             clk,
   input  logic             resetb,
   input  logic             enable,
   input  logic             valid,
   input  payload_t         item,
   di_bus_if.terminal       bus,
   output di_pkg::di_resp_t resp
);
   import di_pkg::*;
   import stream_pkg::*;

   localparam int PTR_W  = $clog2(`CAPTURE_DEPTH);
   localparam int CNT_W  = $clog2(`CAPTURE_DEPTH + 1);
   localparam int DATA_W = $bits(payload_t) - $bits(dtype_t);

   payload_t         mem [`CAPTURE_DEPTH];
   payload_t         head;
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             enable_q;
   logic             armed;
   logic             storing;
   logic             overflow;
   logic             empty;
   logic             full;
   logic             take;
   logic             push;
   logic             pop;

   assign empty = (count == '0);
   assign full  = (count == CNT_W'(`CAPTURE_DEPTH));
   // capture begins on the first frame start after arming.
   assign take  = valid && (storing || (armed && item.dtype == DTYPE_FRAME_START));
   assign push  = take && !full;
   assign pop   = bus.sel && bus.read && (bus.reg_addr == CAP_DATA) && !empty;
   assign head  = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (!resetb) begin
         enable_q <= 1'b0;
         armed    <= 1'b0;
         storing  <= 1'b0;
         overflow <= 1'b0;
         count    <= '0;
         wr_ptr   <= '0;
         rd_ptr   <= '0;
      end else begin
         enable_q <= enable;
         if (!enable) begin
            armed    <= 1'b0;
            storing  <= 1'b0;
            overflow <= 1'b0;
            count    <= '0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
         end else begin
            if (!enable_q) armed <= 1'b1;
            if (take) storing <= 1'b1;
            if (take && full) overflow <= 1'b1;
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop) begin
               count <= count + 1'b1;
            end else if (pop && !push) begin
               count <= count - 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (push) mem[wr_ptr] <= item;
   end

   // bus readout.
   always_comb begin
      resp          = '0;
      resp.read_rdy = !empty;
      case (bus.reg_addr)
         CAP_DATA: begin
            if (!empty) resp.datao[DATA_W-1:0] = head.data;
         end
         CAP_INFO: begin
            if (!empty) resp.datao[1:0] = head.dtype;
            resp.datao[8]            = overflow;
            resp.datao[16 +: CNT_W]  = count;
         end
         default: ;
      endcase
   end

   // the host reads data only while an entry is stored.
   assert property (@(posedge clk) disable iff (!resetb)
      (bus.sel && bus.read && bus.reg_addr == CAP_DATA) |-> !empty);

endmodule

/* rtl/imager_test_top.sv */
`timescale 1ns/1ns
`include "imager_defs.svh"

module imager_test_top (
   input  logic                      clk,
   input  logic                      resetb,
   input  logic [15:0]               di_term_addr,
   input  logic [`DI_ADDR_WIDTH-1:0] di_reg_addr,
   input  logic                      di_read,
   input  logic                      di_write,
   input  logic [`DI_DATA_WIDTH-1:0] di_reg_datai,
   output logic [`DI_DATA_WIDTH-1:0] di_reg_datao,
   output logic                      di_read_rdy,
   output logic                      di_write_rdy,
   output logic [15:0]               di_transfer_status
);
   import di_pkg::*;
   import stream_pkg::*;

   di_resp_t              cfg_resp;
   di_resp_t              in_resp;
   di_resp_t              out_resp;
   logic                  enable;
   stream_sel_t           stream_sel;
   logic [`DIM_WIDTH-1:0] rows;
   logic [`DIM_WIDTH-1:0] cols;
   pixel_t                seed;
   logic                  img_valid;
   dtype_t                img_dtype;
   pixel_t                img_pixel;
   raw_item_t             raw_item;
   logic                  fmt_valid;
   fmt_item_t             fmt_item;

   di_bus_if cfg_bus ();
   di_bus_if in_bus ();
   di_bus_if out_bus ();

   //**********************************************************************
   // register bus
   //**********************************************************************
   di_term_decoder u_decoder (
      .term_addr       (term_t'(di_term_addr)),
      .reg_addr        (di_reg_addr),
      .reg_datai       (di_reg_datai),
      .read            (di_read),
      .write           (di_write),
      .cfg_resp        (cfg_resp),
      .in_resp         (in_resp),
      .out_resp        (out_resp),
      .reg_datao       (di_reg_datao),
      .read_rdy        (di_read_rdy),
      .write_rdy       (di_write_rdy),
      .transfer_status (di_transfer_status),
      .cfg_bus         (cfg_bus),
      .in_bus          (in_bus),
      .out_bus         (out_bus)
   );

   config_terminal u_config (
      .clk        (clk),
      .resetb     (resetb),
      .bus        (cfg_bus),
      .resp       (cfg_resp),
      .enable     (enable),
      .stream_sel (stream_sel),
      .rows       (rows),
      .cols       (cols),
      .seed       (seed)
   );

   //**********************************************************************
   // stream path
   //**********************************************************************
   pattern_imager u_imager (
      .clk    (clk),
      .resetb (resetb),
      .enable (enable),
      .rows   (rows),
      .cols   (cols),
      .seed   (seed),
      .valid  (img_valid),
      .dtype  (img_dtype),
      .pixel  (img_pixel)
   );

   assign raw_item = '{dtype: img_dtype, data: img_pixel};

   pixel_formatter u_formatter (
      .clk        (clk),
      .resetb     (resetb),
      .stream_sel (stream_sel),
      .valid      (img_valid),
      .dtype      (img_dtype),
      .pixel      (img_pixel),
      .fmt_valid  (fmt_valid),
      .fmt_item   (fmt_item)
   );

   capture_fifo #(.payload_t(raw_item_t)) u_cap_in (
      .clk    (clk),
      .resetb (resetb),
      .enable (enable),
      .valid  (img_valid),
      .item   (raw_item),
      .bus    (in_bus),
      .resp   (in_resp)
   );

   capture_fifo #(.payload_t(fmt_item_t)) u_cap_out (
      .clk    (clk),
      .resetb (resetb),
      .enable (enable),
      .valid  (fmt_valid),
      .item   (fmt_item),
      .bus    (out_bus),
      .resp   (out_resp)
   );

endmodule

/* test/tb_imager_test.sv */
`timescale 1ns/1ns
`include "imager_defs.svh"

module tb_imager_test;
   import di_pkg::*;
   import stream_pkg::*;

   logic                      clk;
   logic                      resetb;
   logic [15:0]               di_term_addr;
   logic [`DI_ADDR_WIDTH-1:0] di_reg_addr;
   logic                      di_read;
   logic                      di_write;
   logic [`DI_DATA_WIDTH-1:0] di_reg_datai;
   logic [`DI_DATA_WIDTH-1:0] di_reg_datao;
   logic                      di_read_rdy;
   logic                      di_write_rdy;
   logic [15:0]               di_transfer_status;

   // last bus read response, sampled at the falling edge.
   logic [31:0]               rd_data;
   logic                      rd_read_rdy;
   logic                      rd_write_rdy;
   logic [15:0]               rd_status;

   string                     test_name;
   string                     line;
   int                        fd;
   int                        n;
   int                        tests_run;
   logic [127:0]              name_code;
   int                        rows;
   int                        cols;
   logic [9:0]                seed;
   int                        sel;

   imager_test_top u_dut (
      .clk                (clk),
      .resetb             (resetb),
      .di_term_addr       (di_term_addr),
      .di_reg_addr        (di_reg_addr),
      .di_read            (di_read),
      .di_write           (di_write),
      .di_reg_datai       (di_reg_datai),
      .di_reg_datao       (di_reg_datao),
      .di_read_rdy        (di_read_rdy),
      .di_write_rdy       (di_write_rdy),
      .di_transfer_status (di_transfer_status)
   );

   always #5 clk = ~clk;

   //********************************************************************
   // reporting and bus access
   //********************************************************************
   task automatic fail_run(input string msg);
      $display("%0s", msg);
      $display("Done: errors found");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         fail_run($sformatf("ERROR %0s: %0s expected %0h actual %0h",
                            test_name, what, expected, actual));
      end
   endtask

   task automatic bus_write(input logic [15:0] term, input logic [31:0] addr,
                            input logic [31:0] data);
      @(posedge clk);
      di_term_addr <= term;
      di_reg_addr  <= addr;
      di_reg_datai <= data;
      di_write     <= 1'b1;
      @(posedge clk);
      di_write     <= 1'b0;
   endtask

   // a read of CAP_DATA pops at the closing edge.
   task automatic bus_read(input logic [15:0] term, input logic [31:0] addr);
      @(posedge clk);
      di_term_addr <= term;
      di_reg_addr  <= addr;
      di_read      <= 1'b1;
      @(negedge clk);
      rd_data      = di_reg_datao;
      rd_read_rdy  = di_read_rdy;
      rd_write_rdy = di_write_rdy;
      rd_status    = di_transfer_status;
      @(posedge clk);
      di_read      <= 1'b0;
   endtask

   //********************************************************************
   // reference model
   //********************************************************************
   function automatic logic [9:0] model_pixel(input logic [9:0] base, input int k);
      return 10'((int'(base) + k) % 1024);
   endfunction

   function automatic logic [1:0] model_dtype(input int k, input int line_len);
      if (k == 0) begin
         return DTYPE_FRAME_START;
      end else if (k % line_len == 0) begin
         return DTYPE_LINE_START;
      end
      return DTYPE_PIXEL;
   endfunction

   //********************************************************************
   // test steps
   //********************************************************************
   task automatic check_config(input logic [31:0] addr, input logic [31:0] expected);
      bus_read(TERM_CONFIG, addr);
      check_value($sformatf("config reg %0d", addr), expected, rd_data);
      check_value("config flags", {1'b1, 1'b1, 16'd0},
                  {rd_read_rdy, rd_write_rdy, rd_status});
   endtask

   task automatic check_empty(input logic [15:0] term);
      bus_read(term, CAP_INFO);
      check_value($sformatf("term %0d empty info", term), 32'd0, rd_data);
      check_value($sformatf("term %0d empty flags", term), 32'd0,
                  {rd_read_rdy, rd_write_rdy, rd_status});
   endtask

   task automatic wait_level(input logic [15:0] term, input int expected);
      int polls;
      polls = 0;
      bus_read(term, CAP_INFO);
      while (int'(rd_data[20:16]) < expected) begin
         polls++;
         if (polls > 500) begin
            fail_run($sformatf("timeout in %0s: terminal %0d never held %0d entries",
                               test_name, term, expected));
         end
         bus_read(term, CAP_INFO);
      end
   endtask

   task automatic check_capture(input logic [15:0] term, input int count, input int line_len,
                                input logic [9:0] base, input logic packed_mode);
      int          k;
      logic [31:0] exp_data;
      for (int i = 0; i < count; i++) begin
         k = packed_mode ? 2 * i : i;
         if (packed_mode) begin
            exp_data = {6'd0, model_pixel(base, k + 1), 6'd0, model_pixel(base, k)};
         end else begin
            exp_data = {22'd0, model_pixel(base, k)};
         end
         bus_read(term, CAP_INFO);
         check_value($sformatf("term %0d entry %0d dtype", term, i),
                     model_dtype(k, line_len), rd_data[1:0]);
         check_value($sformatf("term %0d read_rdy", term), 32'd1, rd_read_rdy);
         bus_read(term, CAP_DATA);
         check_value($sformatf("term %0d entry %0d data", term, i), exp_data, rd_data);
      end
   endtask

   task automatic run_test(input int n_rows, input int n_cols, input logic [9:0] base,
                           input logic packed_mode);
      int items;
      int out_items;
      int in_count;
      int out_count;
      items     = n_rows * n_cols;
      out_items = packed_mode ? items / 2 : items;
      in_count  = (items < `CAPTURE_DEPTH) ? items : `CAPTURE_DEPTH;
      out_count = (out_items < `CAPTURE_DEPTH) ? out_items : `CAPTURE_DEPTH;

      bus_write(TERM_CONFIG, CFG_ENABLE, 32'd0);
      bus_write(TERM_CONFIG, CFG_ROWS, n_rows);
      bus_write(TERM_CONFIG, CFG_COLS, n_cols);
      bus_write(TERM_CONFIG, CFG_SEED, {22'd0, base});
      bus_write(TERM_CONFIG, CFG_STREAM_SEL, {31'd0, packed_mode});
      bus_write(TERM_CONFIG, CFG_ENABLE, 32'd1);
      check_config(CFG_ENABLE, 32'd1);
      check_config(CFG_STREAM_SEL, {31'd0, packed_mode});
      check_config(CFG_ROWS, n_rows);
      check_config(CFG_COLS, n_cols);
      check_config(CFG_SEED, {22'd0, base});

      wait_level(TERM_CAPTURE_IN, in_count);
      wait_level(TERM_CAPTURE_OUT, out_count);
      check_capture(TERM_CAPTURE_IN, in_count, n_cols, base, 1'b0);
      check_capture(TERM_CAPTURE_OUT, out_count, n_cols, base, packed_mode);

      // a frame larger than the buffer leaves the sticky overflow bit.
      if (items > `CAPTURE_DEPTH) begin
         bus_read(TERM_CAPTURE_IN, CAP_INFO);
         check_value("input overflow", 32'd1, rd_data[8]);
      end
      if (out_items > `CAPTURE_DEPTH) begin
         bus_read(TERM_CAPTURE_OUT, CAP_INFO);
         check_value("output overflow", 32'd1, rd_data[8]);
      end

      bus_write(TERM_CONFIG, CFG_ENABLE, 32'd0);
      check_empty(TERM_CAPTURE_IN);
      check_empty(TERM_CAPTURE_OUT);
   endtask

   //********************************************************************
   // main sequence
   //********************************************************************
   initial begin
      clk          = 1'b0;
      resetb       = 1'b0;
      di_term_addr = '0;
      di_reg_addr  = '0;
      di_read      = 1'b0;
      di_write     = 1'b0;
      di_reg_datai = '0;
      tests_run    = 0;
      test_name    = "bus_defaults";
      repeat (4) @(posedge clk);
      resetb <= 1'b1;

      // unknown terminals get the default answer.
      bus_read(16'h0000, CFG_ENABLE);
      check_value("unknown terminal data", 32'd0, rd_data);
      check_value("unknown terminal flags", {1'b1, 1'b1, 16'd1},
                  {rd_read_rdy, rd_write_rdy, rd_status});
      bus_read(16'h00ff, CFG_COLS);
      check_value("unknown terminal flags", {1'b1, 1'b1, 16'd1},
                  {rd_read_rdy, rd_write_rdy, rd_status});
      check_empty(TERM_CAPTURE_IN);
      check_empty(TERM_CAPTURE_OUT);
      check_config(32'd7, 32'd0);

      fd = $fopen("test/imager_stim.txt", "r");
      if (fd == 0) begin
         fail_run("could not open the stimulus file test/imager_stim.txt");
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (n > 1 && line.getc(0) != "#") begin
            n = $sscanf(line, "%s %d %d %h %d", name_code, rows, cols, seed, sel);
            if (n == 5) begin
               test_name = $sformatf("%0s", name_code);
               run_test(rows, cols, seed, sel != 0);
               tests_run++;
            end
         end
      end
      $fclose(fd);

      if (tests_run > 0) begin
         $display("Done: no errors");
         $finish;
      end else begin
         fail_run("no test lines were read from test/imager_stim.txt");
      end
   end

endmodule

/* test/imager_stim.txt */
# name rows cols seed(hex) stream_sel(0 raw, 1 packed)
# captured entries follow from the counting pattern (seed + k) mod 1024
raw_small     2  3   005 0
raw_wrap      3  4   3fd 0
raw_narrow    4  2   3ff 0
raw_single    1  1   000 0
raw_overflow  5  6   100 0
raw_wide      1  20  3f0 0
packed_small  2  4   010 1
packed_wrap   2  6   3fa 1
packed_pair   1  2   123 1
packed_over   4  10  200 1

/* project.f */
+incdir+rtl
rtl/di_pkg.sv
rtl/stream_pkg.sv
rtl/di_bus_if.sv
rtl/di_term_decoder.sv
rtl/config_terminal.sv
rtl/pattern_imager.sv
rtl/pixel_formatter.sv
rtl/capture_fifo.sv
rtl/imager_test_top.sv
test/tb_imager_test.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the imager testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
   --top-module tb_imager_test -f project.f -o tb_imager_test
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_imager_test > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
fi

if grep -qx "Done: no errors" "$log"; then
   exit 0
fi
echo "simulation failed, see $log"
exit 1
